/* Bender.yml */
package:
  name: pm_fabric

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pm_bus_pkg.sv
      - hw/pm_dev_pkg.sv
      - hw/pm_bus_decode.sv
      - hw/pm_ram.sv
      - hw/pm_pio.sv
      - hw/pm_tmr.sv
      - hw/pm_irq.sv
      - hw/pm_read_return.sv
      - hw/pm_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_pm_top.sv

/* bench/tb_clk_gen.sv */
// Clock period and reset length are fixed by parameters and reset is released 2 ns after an edge
`timescale 1ns/1ps

module tb_clk_gen
#(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 3
)
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2 rst_n = 1'b1;    // Same offset as the stimulus
    end

endmodule

/* bench/tb_pm_top.sv */
// Builds the DUT with an 8-clock timer beat and expects read data exactly one cycle after the strobe
`timescale 1ns/1ps
`include "pm_settings.svh"

module tb_pm_top
    import pm_bus_pkg::*, pm_dev_pkg::*;
();

    localparam int tb_beat     = 8;
    localparam int ram_n       = 32;
    localparam int len_reset   = 4;
    localparam int len_ram     = 4 * ram_n + ram_n + 4;     // Two write passes, then reads
    localparam int len_unmap   = 30;
    localparam int len_pio     = 30;
    localparam int len_tmr     = 200 + 30;
    localparam int len_irq     = 20 + 4 * tb_beat + 80;
    localparam int cycle_limit = 2 * (len_reset + len_ram + len_unmap + len_pio + len_tmr
                                      + len_irq);

    typedef struct packed {
        logic        chk;
        pm_adr_t     adr;
        logic [31:0] word;
    } exp_t;

    logic                      clk;
    logic                      rst_n;
    pm_core_req_t              core_req;
    logic [31:0]               rdata;
    logic [`PM_PIO_IN_W-1:0]   pio_in;
    logic [`PM_PIO_OUT_W-1:0]  pio_out;
    logic [1:0]                irq_ext;
    logic                      irq;

    // Reference state
    logic [31:0]               ram_m [`PM_RAM_WORDS];
    logic [`PM_PIO_OUT_W-1:0]  m_out;
    logic [`PM_PIO_IN_W-1:0]   m_mask;
    logic [31:0]               m_count;
    logic [31:0]               m_alarm;
    logic                      m_en;
    logic [3:0]                m_pend;
    logic [3:0]                m_enable;

    exp_t                      exp_q [$];   // One entry per read in flight
    logic                      rd_q;
    logic [31:0]               last_rdata;
    logic [31:0]               lcg_state = 32'd80;
    logic [`PM_RAM_ADR_W-1:0]  words [ram_n];
    int                        errors = 0;
    int                        checks = 0;
    int                        cycles = 0;

    tb_clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pm_top #(.beat_div(tb_beat)) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .core_req (core_req),
        .rdata    (rdata),
        .pio_in   (pio_in),
        .pio_out  (pio_out),
        .irq_ext  (irq_ext),
        .irq      (irq)
    );

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic pm_adr_t ram_adr(input logic [`PM_RAM_ADR_W-1:0] w);
        pm_adr_t a;
        a            = '0;
        a.ram.region = `PM_REGION_RAM;
        a.ram.word   = w;
        return a;
    endfunction

    function automatic pm_adr_t reg_adr(input logic [3:0] dev, input logic [2:0] idx);
        pm_adr_t a;
        a            = '0;
        a.per.region = `PM_REGION_PERIPH;
        a.per.dev    = dev;
        a.per.idx    = idx;
        return a;
    endfunction

    // Expected read word from the address map and register rules
    function automatic logic [31:0] ref_read(input pm_adr_t a);
        logic [31:0] w;
        w = '0;
        if (a.ram.region == `PM_REGION_RAM)
            w = ram_m[a.ram.word];
        else if (a.per.region == `PM_REGION_PERIPH)
        begin
            case (a.per.dev)
                `PM_DEV_PIO:
                    case (a.per.idx)
                        pio_version :
                        begin
                            w[15:8] = `PM_HW_VER_MAJOR;
                            w[7:0]  = `PM_HW_VER_MINOR;
                        end
                        pio_input   :
                        begin
                            w[`PM_PIO_IN_W+1:2] = pio_in;   // Pins above the flags
                            w[1]                = (`PM_SPL == 4);
                            w[0]                = (`PM_SIM != 0);
                        end
                        pio_output  : w[`PM_PIO_OUT_W-1:0] = m_out;
                        pio_mask    : w[`PM_PIO_IN_W-1:0] = m_mask;
                        default     : w = '0;
                    endcase
                `PM_DEV_TMR:
                    case (a.per.idx)
                        tmr_count   : w = m_count;
                        tmr_alarm   : w = m_alarm;
                        tmr_control : w[0] = m_en;
                        default     : w = '0;
                    endcase
                `PM_DEV_IRQ:
                    case (a.per.idx)
                        irq_pending : w[3:0] = m_pend;
                        irq_enable  : w[3:0] = m_enable;
                        default     : w = '0;
                    endcase
                default : w = '0;   // Unmapped device
            endcase
        end
        return w;
    endfunction

    task automatic model_write(input pm_adr_t a, input logic [3:0] strb, input logic [31:0] dat);
        if (a.ram.region == `PM_REGION_RAM)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (strb[i])
                    ram_m[a.ram.word][8*i +: 8] = dat[8*i +: 8];
            end
        end
        else if (a.per.region == `PM_REGION_PERIPH)
        begin
            if (a.per.dev == `PM_DEV_PIO && a.per.idx == pio_output)
                m_out = dat[`PM_PIO_OUT_W-1:0];
            if (a.per.dev == `PM_DEV_PIO && a.per.idx == pio_mask)
                m_mask = dat[`PM_PIO_IN_W-1:0];
            if (a.per.dev == `PM_DEV_TMR && a.per.idx == tmr_count)
                m_count = dat;
            if (a.per.dev == `PM_DEV_TMR && a.per.idx == tmr_alarm)
                m_alarm = dat;
            if (a.per.dev == `PM_DEV_TMR && a.per.idx == tmr_control)
                m_en = dat[0];
            if (a.per.dev == `PM_DEV_IRQ && a.per.idx == irq_pending)
                m_pend = m_pend & ~dat[3:0];    // Write one to clear
            if (a.per.dev == `PM_DEV_IRQ && a.per.idx == irq_enable)
                m_enable = dat[3:0];
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_range(input string what, input logic [31:0] got,
                               input logic [31:0] lo, input logic [31:0] hi);
        checks++;
        if ($isunknown(got) || got < lo || got > hi)
        begin
            errors++;
            $display("ERROR %0t: %s gave %0d, expected %0d to %0d", $time, what, got, lo, hi);
        end
    endtask

    task automatic check_irq(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t: irq %b at %s, expected %b", $time, got, what, exp);
        end
    endtask

    task automatic drive(input pm_core_req_t req);
        @(posedge clk);
        #2;
        core_req = req;
    endtask

    task automatic idle(input int n);
        repeat (n) drive('0);
    endtask

    task automatic write_word(input pm_adr_t a, input logic [3:0] strb, input logic [31:0] dat);
        pm_core_req_t req;
        req        = '0;
        req.wr     = 1'b1;
        req.wr_adr = a;
        req.strb   = strb;
        req.dat    = dat;
        drive(req);
        model_write(a, strb, dat);
        drive('0);
    endtask

    // One cycle only, so reads can follow back to back
    task automatic read_word(input pm_adr_t a, input logic chk);
        pm_core_req_t req;
        exp_t         e;
        req        = '0;
        req.rd     = 1'b1;
        req.rd_adr = a;
        e.chk      = chk;
        e.adr      = a;
        e.word     = ref_read(a);
        exp_q.push_back(e);
        drive(req);
    endtask

    task automatic wait_irq(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (irq !== 1'b1 && n < max_cycles)
        begin
            @(negedge clk);
            n++;
        end
    endtask

    always @(posedge clk)
        rd_q <= core_req.rd;

    // Read word is stable between the two edges after the strobe
    always @(negedge clk)
    begin : compare
        exp_t e;
        if (rd_q === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("A read returned data but no expected value was queued");
            end
            else
            begin
                e = exp_q.pop_front();
                if (e.chk)
                    check_word($sformatf("read of %h", e.adr), rdata, e.word);
                else
                    last_rdata = rdata;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    initial
    begin : stimulus
        pm_adr_t     a;
        logic [31:0] d;
        int          k;
        core_req = '0;
        pio_in   = '0;
        irq_ext  = '0;
        m_out    = '0;
        m_mask   = '0;
        m_count  = '0;
        m_alarm  = '0;
        m_en     = 1'b0;
        m_pend   = '0;
        m_enable = '0;
        @(posedge rst_n);
        idle(1);

        // Full words first so no byte stays undefined
        for (int i = 0; i < ram_n; i++)
        begin
            d        = lcg_next();
            words[i] = d[`PM_RAM_ADR_W-1:0];
            write_word(ram_adr(words[i]), 4'hf, lcg_next());
        end
        for (int i = 0; i < ram_n; i++)
        begin
            d = lcg_next();
            write_word(ram_adr(words[i]), d[3:0], lcg_next());
        end
        for (int i = 0; i < ram_n; i++)
            read_word(ram_adr(words[i]), 1'b1);
        idle(2);

        a            = ram_adr(words[0]);
        a.ram.region = 2'b01;
        write_word(a, 4'hf, lcg_next());
        read_word(a, 1'b1);
        a.ram.region = 2'b00;
        read_word(a, 1'b1);
        a = reg_adr(4'd7, pio_output);
        write_word(a, 4'hf, lcg_next());
        read_word(a, 1'b1);
        write_word(reg_adr(`PM_DEV_PIO, pio_version), 4'hf, lcg_next());   // Read-only
        read_word(ram_adr(words[0]), 1'b1);
        read_word(reg_adr(`PM_DEV_PIO, pio_output), 1'b1);
        read_word(reg_adr(`PM_DEV_PIO, pio_version), 1'b1);
        idle(2);

        write_word(reg_adr(`PM_DEV_PIO, pio_output), 4'hf, lcg_next());
        check_word("pio_out pins", pio_out, m_out);
        read_word(reg_adr(`PM_DEV_PIO, pio_output), 1'b1);
        d = lcg_next();
        drive('0);
        pio_in = d[`PM_PIO_IN_W-1:0];
        idle(2);
        read_word(reg_adr(`PM_DEV_PIO, pio_input), 1'b1);
        read_word(reg_adr(`PM_DEV_PIO, pio_mask), 1'b1);
        idle(2);

        write_word(reg_adr(`PM_DEV_TMR, tmr_control), 4'hf, 32'h1);
        idle(200);
        read_word(reg_adr(`PM_DEV_TMR, tmr_count), 1'b0);
        idle(2);
        check_range("timer count after 200 cycles", last_rdata,
                    200 / tb_beat - 1, 200 / tb_beat + 1);
        write_word(reg_adr(`PM_DEV_TMR, tmr_control), 4'hf, 32'h0);
        write_word(reg_adr(`PM_DEV_TMR, tmr_count), 4'hf, lcg_next());
        read_word(reg_adr(`PM_DEV_TMR, tmr_count), 1'b1);
        read_word(reg_adr(`PM_DEV_TMR, tmr_control), 1'b1);
        idle(2);

        write_word(reg_adr(`PM_DEV_PIO, pio_mask), 4'hf, 32'hff);
        write_word(reg_adr(`PM_DEV_IRQ, irq_enable), 4'hf, 32'hf);
        drive('0);
        pio_in[0] = ~pio_in[0];
        m_pend[0] = 1'b1;   // Masked pin change
        wait_irq(8);
        check_irq("PIO change", irq, 1'b1);
        read_word(reg_adr(`PM_DEV_IRQ, irq_pending), 1'b1);
        idle(2);
        write_word(reg_adr(`PM_DEV_IRQ, irq_pending), 4'hf, 32'h1);
        idle(2);
        check_irq("PIO pending clear", irq, 1'b0);

        // Alarm two beats ahead of the stopped count
        write_word(reg_adr(`PM_DEV_TMR, tmr_alarm), 4'hf, m_count + 32'd2);
        write_word(reg_adr(`PM_DEV_TMR, tmr_control), 4'hf, 32'h1);
        m_pend[1] = 1'b1;
        wait_irq(3 * tb_beat + 4);
        check_irq("timer alarm", irq, 1'b1);
        read_word(reg_adr(`PM_DEV_IRQ, irq_pending), 1'b1);
        idle(2);
        write_word(reg_adr(`PM_DEV_TMR, tmr_control), 4'hf, 32'h0);
        write_word(reg_adr(`PM_DEV_IRQ, irq_pending), 4'hf, 32'h2);

        d = lcg_next();
        k = d[0];
        drive('0);
        irq_ext[k] = 1'b1;      // Single-cycle pulse
        drive('0);
        irq_ext = '0;
        m_pend[2 + k] = 1'b1;
        wait_irq(6);
        check_irq("external request", irq, 1'b1);
        read_word(reg_adr(`PM_DEV_IRQ, irq_pending), 1'b1);
        idle(2);
        write_word(reg_adr(`PM_DEV_IRQ, irq_pending), 4'hf, 32'hc);
        write_word(reg_adr(`PM_DEV_IRQ, irq_enable), 4'hf, 32'h0);

        drive('0);
        pio_in[0] = ~pio_in[0];
        m_pend[0] = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            check_irq("change with ENABLE cleared", irq, 1'b0);
        end
        read_word(reg_adr(`PM_DEV_IRQ, irq_pending), 1'b1);
        read_word(reg_adr(`PM_DEV_IRQ, irq_enable), 1'b1);
        idle(2);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* hw/pm_bus_decode.sv */
// Purely combinational and accesses outside the RAM and the three devices are dropped
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_bus_decode
    import pm_bus_pkg::*;
(
    input  pm_core_req_t              core_req,
    output logic                      ram_wr,
    output logic                      ram_rd,
    output logic [`PM_RAM_ADR_W-1:0]  ram_wr_adr,
    output logic [`PM_RAM_ADR_W-1:0]  ram_rd_adr,
    output pm_lb_t                    pio_lb,
    output pm_lb_t                    tmr_lb,
    output pm_lb_t                    irq_lb,
    output pm_src_t                   rd_src
);

    logic per_wr;
    logic per_rd;

    // Register index follows the write address while that device is written
    function automatic pm_lb_t make_lb(input logic wr, input logic rd, input pm_core_req_t req);
        pm_lb_t lb;
        lb.wr  = wr;
        lb.rd  = rd;
        lb.adr = wr ? req.wr_adr.per.idx : req.rd_adr.per.idx;
        lb.dat = req.dat;
        return lb;
    endfunction

    assign ram_wr     = core_req.wr && (core_req.wr_adr.ram.region == `PM_REGION_RAM);
    assign ram_rd     = core_req.rd && (core_req.rd_adr.ram.region == `PM_REGION_RAM);
    assign ram_wr_adr = core_req.wr_adr.ram.word;
    assign ram_rd_adr = core_req.rd_adr.ram.word;

    assign per_wr = core_req.wr && (core_req.wr_adr.per.region == `PM_REGION_PERIPH);
    assign per_rd = core_req.rd && (core_req.rd_adr.per.region == `PM_REGION_PERIPH);

    assign pio_lb = make_lb(per_wr && (core_req.wr_adr.per.dev == `PM_DEV_PIO),
                            per_rd && (core_req.rd_adr.per.dev == `PM_DEV_PIO), core_req);
    assign tmr_lb = make_lb(per_wr && (core_req.wr_adr.per.dev == `PM_DEV_TMR),
                            per_rd && (core_req.rd_adr.per.dev == `PM_DEV_TMR), core_req);
    assign irq_lb = make_lb(per_wr && (core_req.wr_adr.per.dev == `PM_DEV_IRQ),
                            per_rd && (core_req.rd_adr.per.dev == `PM_DEV_IRQ), core_req);

    always_comb
    begin
        rd_src = src_none;      // Unmapped reads return zero
        if (ram_rd)
            rd_src = src_ram;
        else if (pio_lb.rd)
            rd_src = src_pio;
        else if (tmr_lb.rd)
            rd_src = src_tmr;
        else if (irq_lb.rd)
            rd_src = src_irq;
    end

endmodule

/* hw/pm_bus_pkg.sv */
// Bus types assume 16-bit byte addresses, 32-bit words and a RAM below 16 KB
`include "pm_settings.svh"

package pm_bus_pkg;

    // Address seen as a RAM word
    typedef struct packed {
        logic [1:0]                     region;
        logic [11-`PM_RAM_ADR_W:0]      unused;
        logic [`PM_RAM_ADR_W-1:0]       word;
        logic [1:0]                     ofs;
    } pm_ram_view_t;

    // Same address seen as a device register
    typedef struct packed {
        logic [1:0] region;
        logic [1:0] unused_hi;
        logic [3:0] dev;        // Bits 11:8
        logic [2:0] unused_lo;
        logic [2:0] idx;        // Bits 4:2
        logic [1:0] ofs;
    } pm_per_view_t;

    typedef union packed {
        pm_ram_view_t ram;
        pm_per_view_t per;
    } pm_adr_t;

    // Core data port
    typedef struct packed {
        logic        wr;
        pm_adr_t     wr_adr;
        logic        rd;
        pm_adr_t     rd_adr;
        logic [3:0]  strb;
        logic [31:0] dat;
    } pm_core_req_t;

    // Local bus towards one device
    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [2:0]  adr;
        logic [31:0] dat;
    } pm_lb_t;

    typedef enum logic [2:0] {src_none, src_ram, src_pio, src_tmr, src_irq} pm_src_t;

endpackage

/* hw/pm_dev_pkg.sv */
// Register indices are word offsets inside each 256-byte device slot
package pm_dev_pkg;

    typedef enum logic [2:0] {
        pio_version = 3'd0,
        pio_input   = 3'd1,
        pio_output  = 3'd2,
        pio_mask    = 3'd3
    } pm_pio_reg_t;

    typedef enum logic [2:0] {
        tmr_count   = 3'd0,
        tmr_alarm   = 3'd1,
        tmr_control = 3'd2
    } pm_tmr_reg_t;

    typedef enum logic [2:0] {
        irq_pending = 3'd0,
        irq_enable  = 3'd1
    } pm_irq_reg_t;

    // Bit 0 PIO, bit 1 timer, bits 3:2 external
    typedef struct packed {
        logic [1:0] ext;
        logic       tmr;
        logic       pio;
    } pm_irq_vec_t;

endpackage

/* hw/pm_irq.sv */
// Requests are single-cycle pulses and a request in the clear cycle keeps its bit pending
`timescale 1ns/1ps

module pm_irq
    import pm_bus_pkg::*, pm_dev_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  pm_lb_t       lb,
    output logic [31:0]  dout,
    input  pm_irq_vec_t  req,
    output logic         irq
);

    logic [3:0] pending;
    logic [3:0] enable;
    logic [3:0] clr;

    // Write one to clear
    assign clr = (lb.wr && (lb.adr == irq_pending)) ? lb.dat[3:0] : 4'h0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending <= '0;
            enable  <= '0;
            irq     <= 1'b0;
        end
        else
        begin
            pending <= (pending & ~clr) | req;      // Request wins over clear
            irq     <= |(pending & enable);
            if (lb.wr && (lb.adr == irq_enable))
                enable <= lb.dat[3:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (lb.rd)
        begin
            case (lb.adr)
                irq_pending : dout <= {28'h0, pending};
                irq_enable  : dout <= {28'h0, enable};
                default     : dout <= '0;
            endcase
        end
    end

endmodule

/* hw/pm_pio.sv */
// Pins are sampled without a synchronizer so they must be stable to clk or resynchronized outside
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_pio
    import pm_bus_pkg::*, pm_dev_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  pm_lb_t                    lb,
    output logic [31:0]               dout,
    input  logic [`PM_PIO_IN_W-1:0]   pio_in,
    output logic [`PM_PIO_OUT_W-1:0]  pio_out,
    output logic                      irq_pulse
);

    logic [`PM_PIO_IN_W-1:0]  in_q;     // Sampled pins
    logic [`PM_PIO_IN_W-1:0]  in_prev;
    logic [`PM_PIO_IN_W-1:0]  mask;
    logic [`PM_PIO_OUT_W-1:0] out_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_q      <= '0;
            in_prev   <= '0;
            mask      <= '0;
            out_q     <= '0;
            irq_pulse <= 1'b0;
        end
        else
        begin
            in_q      <= pio_in;
            in_prev   <= in_q;
            irq_pulse <= |((in_q ^ in_prev) & mask);    // Any masked edge
            if (lb.wr && (lb.adr == pio_output))
                out_q <= lb.dat[`PM_PIO_OUT_W-1:0];
            if (lb.wr && (lb.adr == pio_mask))
                mask <= lb.dat[`PM_PIO_IN_W-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (lb.rd)
        begin
            case (lb.adr)
                pio_version : dout <= {16'h0, `PM_HW_VER_MAJOR, `PM_HW_VER_MINOR};
                // Four-symbols-per-lane flag in bit 1, simulation flag in bit 0
                pio_input   : dout <= 32'({in_q, (`PM_SPL == 4), (`PM_SIM != 0)});
                pio_output  : dout <= 32'(out_q);
                pio_mask    : dout <= 32'(mask);
                default     : dout <= '0;
            endcase
        end
    end

    assign pio_out = out_q;

endmodule

/* hw/pm_ram.sv */
// Contents are undefined after reset and a read of the word being written returns the old data
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_ram
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`PM_RAM_ADR_W-1:0]  wr_adr,
    input  logic [`PM_RAM_ADR_W-1:0]  rd_adr,
    input  logic [3:0]                strb,
    input  logic [31:0]               din,
    output logic [31:0]               dout
);

    logic [31:0] mem [`PM_RAM_WORDS];

    // Byte lanes
    always_ff @(posedge clk)
    begin
        if (wr)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (strb[i])
                    mem[wr_adr][8*i +: 8] <= din[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            dout <= '0;
        else if (rd)
            dout <= mem[rd_adr];    // Held until the next read
    end

endmodule

/* hw/pm_read_return.sv */
// Read sources hold their word until the next read so only the source is delayed
`timescale 1ns/1ps

module pm_read_return
    import pm_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  pm_src_t      rd_src,
    input  logic [31:0]  ram_dout,
    input  logic [31:0]  pio_dout,
    input  logic [31:0]  tmr_dout,
    input  logic [31:0]  irq_dout,
    output logic [31:0]  rdata
);

    pm_src_t src_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            src_q <= src_none;
        else
            src_q <= rd_src;
    end

    always_comb
    begin
        case (src_q)
            src_ram : rdata = ram_dout;
            src_pio : rdata = pio_dout;
            src_tmr : rdata = tmr_dout;
            src_irq : rdata = irq_dout;
            default : rdata = '0;     // Unmapped or idle
        endcase
    end

endmodule

/* hw/pm_settings.svh */
// Build constants for the fabric and PM_SIM must be cleared for hardware builds
`ifndef PM_SETTINGS_SVH
`define PM_SETTINGS_SVH

// Data RAM of 4 KB
`define PM_RAM_WORDS        1024
`define PM_RAM_ADR_W        10

// Address map
`define PM_REGION_RAM       2'b10
`define PM_REGION_PERIPH    2'b11
`define PM_DEV_PIO          4'd1
`define PM_DEV_TMR          4'd2
`define PM_DEV_IRQ          4'd3

`define PM_BEAT             125     // Clocks per timer beat

// Version shown in the PIO
`define PM_HW_VER_MAJOR     8'd1
`define PM_HW_VER_MINOR     8'd0

// Flags seen by the software on the PIO input word
`define PM_SIM              1
`define PM_SPL              2
`define PM_PIO_IN_W         8
`define PM_PIO_OUT_W        8

`endif

/* hw/pm_tmr.sv */
// Count wraps at 32 bits and a COUNT write in a beat cycle overrides the increment
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_tmr
    import pm_bus_pkg::*, pm_dev_pkg::*;
#(
    parameter int beat_div = `PM_BEAT      // Clocks per beat
)
(
    input  logic         clk,
    input  logic         rst_n,
    input  pm_lb_t       lb,
    output logic [31:0]  dout,
    output logic         irq_pulse
);

    localparam int pre_w = $clog2(beat_div + 1);

    logic [pre_w-1:0] pre;
    logic             beat;
    logic             en;
    logic [31:0]      count;
    logic [31:0]      count_nxt;
    logic [31:0]      alarm;

    assign beat      = en && (pre == pre_w'(beat_div - 1));
    assign count_nxt = count + 32'd1;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pre       <= '0;
            en        <= 1'b0;
            count     <= '0;
            alarm     <= '0;
            irq_pulse <= 1'b0;
        end
        else
        begin
            if (!en || beat)
                pre <= '0;      // Restart each beat and while stopped
            else
                pre <= pre + 1'b1;
            irq_pulse <= beat && (count_nxt == alarm);
            if (lb.wr && (lb.adr == tmr_count))
                count <= lb.dat;
            else if (beat)
                count <= count_nxt;
            if (lb.wr && (lb.adr == tmr_alarm))
                alarm <= lb.dat;
            if (lb.wr && (lb.adr == tmr_control))
                en <= lb.dat[0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (lb.rd)
        begin
            case (lb.adr)
                tmr_count   : dout <= count;
                tmr_alarm   : dout <= alarm;
                tmr_control : dout <= {31'h0, en};
                default     : dout <= '0;
            endcase
        end
    end

endmodule

/* hw/pm_top.sv */
// Read data is valid exactly one cycle after the read strobe and there is no back-pressure
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_top
    import pm_bus_pkg::*, pm_dev_pkg::*;
#(
    parameter int beat_div = `PM_BEAT
)
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  pm_core_req_t              core_req,
    output logic [31:0]               rdata,
    input  logic [`PM_PIO_IN_W-1:0]   pio_in,
    output logic [`PM_PIO_OUT_W-1:0]  pio_out,
    input  logic [1:0]                irq_ext,
    output logic                      irq
);

    logic                      ram_wr;
    logic                      ram_rd;
    logic [`PM_RAM_ADR_W-1:0]  ram_wr_adr;
    logic [`PM_RAM_ADR_W-1:0]  ram_rd_adr;
    logic [31:0]               ram_dout;
    pm_lb_t                    pio_lb;
    pm_lb_t                    tmr_lb;
    pm_lb_t                    irq_lb;
    pm_src_t                   rd_src;
    logic [31:0]               pio_dout;
    logic [31:0]               tmr_dout;
    logic [31:0]               irq_dout;
    logic                      pio_irq;
    logic                      tmr_irq;
    pm_irq_vec_t               irq_req;

    pm_bus_decode u_decode (
        .core_req   (core_req),
        .ram_wr     (ram_wr),
        .ram_rd     (ram_rd),
        .ram_wr_adr (ram_wr_adr),
        .ram_rd_adr (ram_rd_adr),
        .pio_lb     (pio_lb),
        .tmr_lb     (tmr_lb),
        .irq_lb     (irq_lb),
        .rd_src     (rd_src)
    );

    pm_ram u_ram (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (ram_wr),
        .rd     (ram_rd),
        .wr_adr (ram_wr_adr),
        .rd_adr (ram_rd_adr),
        .strb   (core_req.strb),
        .din    (core_req.dat),
        .dout   (ram_dout)
    );

    pm_pio u_pio (
        .clk       (clk),
        .rst_n     (rst_n),
        .lb        (pio_lb),
        .dout      (pio_dout),
        .pio_in    (pio_in),
        .pio_out   (pio_out),
        .irq_pulse (pio_irq)
    );

    pm_tmr #(.beat_div(beat_div)) u_tmr (
        .clk       (clk),
        .rst_n     (rst_n),
        .lb        (tmr_lb),
        .dout      (tmr_dout),
        .irq_pulse (tmr_irq)
    );

    assign irq_req = '{ext: irq_ext, tmr: tmr_irq, pio: pio_irq};

    pm_irq u_irq (
        .clk   (clk),
        .rst_n (rst_n),
        .lb    (irq_lb),
        .dout  (irq_dout),
        .req   (irq_req),
        .irq   (irq)
    );

    pm_read_return u_return (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_src   (rd_src),
        .ram_dout (ram_dout),
        .pio_dout (pio_dout),
        .tmr_dout (tmr_dout),
        .irq_dout (irq_dout),
        .rdata    (rdata)
    );

endmodule

/* tb.f */
+incdir+hw
hw/pm_bus_pkg.sv
hw/pm_dev_pkg.sv
hw/pm_bus_decode.sv
hw/pm_ram.sv
hw/pm_pio.sv
hw/pm_tmr.sv
hw/pm_irq.sv
hw/pm_read_return.sv
hw/pm_top.sv
bench/tb_clk_gen.sv
bench/tb_pm_top.sv
